// File: cpu_top.f
+incdir+design
design/cpu_pkg.sv
design/reg_file.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/mem_wb.sv
design/cpu_top.sv
testbench/tb_cpu_mem.sv
testbench/tb_cpu_top.sv

// File: design/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_XLEN      32
`define CPU_NREG      32
`define CPU_RESET_PC  32'h0000_0000

// Instruction layout, opcode on top and the immediate in the low half
`define CPU_OPC_LSB   28
`define CPU_RD_LSB    23
`define CPU_RJ_LSB    18
`define CPU_RK_LSB    13
`define CPU_IMM_W     16

`endif

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef enum logic [3:0] {
        op_add  = 4'h0, op_sub  = 4'h1, op_and  = 4'h2, op_or   = 4'h3,
        op_xor  = 4'h4, op_slt  = 4'h5, op_addi = 4'h6, op_lui  = 4'h7,
        op_lw   = 4'h8, op_sw   = 4'h9, op_beq  = 4'ha, op_bne  = 4'hb
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

    typedef enum logic {
        ic_idle = 1'b0,
        ic_read = 1'b1
    } icache_op_e;

endpackage

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_top (
    input  logic                  clk,
    input  logic                  arst_n,

    output cpu_pkg::icache_op_e   icache_op,
    output logic [`CPU_XLEN-1:0]  icache_pa,
    input  logic [`CPU_XLEN-1:0]  icache_data,
    input  logic                  icache_busy,
    input  logic                  icache_data_valid,

    output cpu_pkg::mem_op_e      dcache_op,
    output logic [`CPU_XLEN-1:0]  dcache_pa,
    output logic [`CPU_XLEN-1:0]  wr_dcache_data,
    input  logic [`CPU_XLEN-1:0]  rd_dcache_data,
    input  logic                  dcache_busy,
    input  logic                  dcache_data_valid,

    output logic                  debug_wb_valid,
    output logic [`CPU_XLEN-1:0]  debug_wb_pc,
    output logic [`CPU_XLEN-1:0]  debug_wb_inst,
    output logic [3:0]            debug_wb_rf_wen,
    output logic [4:0]            debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0]  debug_wb_rf_wdata
);

    import cpu_pkg::*;

    logic if_valid, id_rdy_in, ex_rdy_in, wb_rdy_in;
    logic [`CPU_XLEN-1:0] if_pc, if_inst;

    logic id_valid, id_is_branch, id_branch_ne, id_we, id_use_imm;
    logic [`CPU_XLEN-1:0] id_pc, id_inst, id_imm, id_a, id_b;
    logic [4:0] id_rd, id_rj, id_rk;
    alu_op_e id_alu_op;
    mem_op_e id_mem_op;

    logic ex_valid, ex_we;
    logic [`CPU_XLEN-1:0] ex_pc, ex_inst, ex_result, ex_store_data;
    logic [4:0] ex_rd;
    mem_op_e ex_mem_op;

    logic [4:0] rf_rj, rf_rk, reg_rd, ex_load_rd, fwd_rd;
    logic [`CPU_XLEN-1:0] rf_rj_data, rf_rk_data, reg_data, fwd_data, target;
    logic reg_we, ex_load_valid, fwd_valid, redirect;
    logic flush_if, flush_id;

    // A taken branch kills everything younger than execute
    assign flush_if = redirect;
    assign flush_id = redirect;

    reg_file u_reg_file (
        .clk, .arst_n,
        .rj(rf_rj), .rk(rf_rk),
        .rj_data(rf_rj_data), .rk_data(rf_rk_data),
        .we(reg_we), .rd(reg_rd), .rd_data(reg_data)
    );

    fetch u_fetch (
        .clk, .arst_n,
        .icache_op, .icache_pa, .icache_data, .icache_busy, .icache_data_valid,
        .flush(flush_if), .target,
        .next_rdy_in(id_rdy_in),
        .out_valid(if_valid), .out_pc(if_pc), .out_inst(if_inst)
    );

    decode u_decode (
        .clk, .arst_n,
        .flush(flush_id), .rdy_in(id_rdy_in),
        .in_valid(if_valid), .in_pc(if_pc), .in_inst(if_inst),
        .rj(rf_rj), .rk(rf_rk), .rj_data(rf_rj_data), .rk_data(rf_rk_data),
        .ex_load_valid, .ex_load_rd,
        .next_rdy_in(ex_rdy_in),
        .out_valid(id_valid), .out_pc(id_pc), .out_inst(id_inst),
        .out_alu_op(id_alu_op), .out_mem_op(id_mem_op),
        .out_is_branch(id_is_branch), .out_branch_ne(id_branch_ne),
        .out_rd(id_rd), .out_rj(id_rj), .out_rk(id_rk), .out_we(id_we),
        .out_imm(id_imm), .out_use_imm(id_use_imm), .out_a(id_a), .out_b(id_b)
    );

    execute u_execute (
        .clk, .arst_n,
        .rdy_in(ex_rdy_in),
        .in_valid(id_valid), .in_pc(id_pc), .in_inst(id_inst),
        .in_alu_op(id_alu_op), .in_mem_op(id_mem_op),
        .in_is_branch(id_is_branch), .in_branch_ne(id_branch_ne),
        .in_rd(id_rd), .in_rj(id_rj), .in_rk(id_rk), .in_we(id_we),
        .in_imm(id_imm), .in_use_imm(id_use_imm), .in_a(id_a), .in_b(id_b),
        .fwd_valid, .fwd_rd, .fwd_data,
        .ex_load_valid, .ex_load_rd,
        .redirect, .target,
        .next_rdy_in(wb_rdy_in),
        .out_valid(ex_valid), .out_pc(ex_pc), .out_inst(ex_inst),
        .out_mem_op(ex_mem_op), .out_rd(ex_rd), .out_we(ex_we),
        .out_result(ex_result), .out_store_data(ex_store_data)
    );

    mem_wb u_mem_wb (
        .clk, .arst_n,
        .rdy_in(wb_rdy_in),
        .in_valid(ex_valid), .in_pc(ex_pc), .in_inst(ex_inst),
        .in_mem_op(ex_mem_op), .in_rd(ex_rd), .in_we(ex_we),
        .in_result(ex_result), .in_store_data(ex_store_data),
        .dcache_op, .dcache_pa, .wr_dcache_data, .rd_dcache_data,
        .dcache_busy, .dcache_data_valid,
        .reg_we, .reg_rd, .reg_data,
        .fwd_valid, .fwd_rd, .fwd_data,
        .debug_wb_valid, .debug_wb_pc, .debug_wb_inst,
        .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

endmodule

`default_nettype wire

// File: design/decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module decode (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    output logic                  rdy_in,
    input  logic                  in_valid,
    input  logic [`CPU_XLEN-1:0]  in_pc,
    input  logic [`CPU_XLEN-1:0]  in_inst,
    output logic [4:0]            rj,
    output logic [4:0]            rk,
    input  logic [`CPU_XLEN-1:0]  rj_data,
    input  logic [`CPU_XLEN-1:0]  rk_data,
    input  logic                  ex_load_valid,
    input  logic [4:0]            ex_load_rd,
    input  logic                  next_rdy_in,
    output logic                  out_valid,
    output logic [`CPU_XLEN-1:0]  out_pc,
    output logic [`CPU_XLEN-1:0]  out_inst,
    output cpu_pkg::alu_op_e      out_alu_op,
    output cpu_pkg::mem_op_e      out_mem_op,
    output logic                  out_is_branch,
    output logic                  out_branch_ne,
    output logic [4:0]            out_rd,
    output logic [4:0]            out_rj,
    output logic [4:0]            out_rk,
    output logic                  out_we,
    output logic [`CPU_XLEN-1:0]  out_imm,
    output logic                  out_use_imm,
    output logic [`CPU_XLEN-1:0]  out_a,
    output logic [`CPU_XLEN-1:0]  out_b
);

    import cpu_pkg::*;

    opcode_e opc;
    alu_op_e alu_op;
    mem_op_e mem_op;
    logic [4:0] f_rd;
    logic [`CPU_IMM_W-1:0] f_imm;
    logic [`CPU_XLEN-1:0] imm;
    logic uses_rj;
    logic uses_rk;
    logic rd_is_src;
    logic writes;
    logic load_use;
    logic take;

    assign opc   = opcode_e'(in_inst[`CPU_OPC_LSB +: 4]);
    assign f_rd  = in_inst[`CPU_RD_LSB +: 5];
    assign f_imm = in_inst[`CPU_IMM_W-1:0];

    // Store and branches take their second source from the rd field
    assign rd_is_src = opc inside {op_sw, op_beq, op_bne};
    assign rj        = in_inst[`CPU_RJ_LSB +: 5];
    assign rk        = rd_is_src ? f_rd : in_inst[`CPU_RK_LSB +: 5];
    assign uses_rj   = opc != op_lui;
    assign uses_rk   = rd_is_src || opc inside {op_add, op_sub, op_and, op_or, op_xor, op_slt};
    assign writes    = opc inside {op_add, op_sub, op_and, op_or, op_xor, op_slt,
                                   op_addi, op_lui, op_lw};
    assign mem_op    = (opc == op_lw) ? mem_load : (opc == op_sw) ? mem_store : mem_none;
    assign imm       = (opc == op_lui) ? {f_imm, {(`CPU_XLEN-`CPU_IMM_W){1'b0}}}
                                       : {{(`CPU_XLEN-`CPU_IMM_W){f_imm[`CPU_IMM_W-1]}}, f_imm};

    always_comb begin
        case (opc)
            op_sub:  alu_op = alu_sub;
            op_and:  alu_op = alu_and;
            op_or:   alu_op = alu_or;
            op_xor:  alu_op = alu_xor;
            op_slt:  alu_op = alu_slt;
            op_lui:  alu_op = alu_lui;
            default: alu_op = alu_add;                  // addi, lw and sw add too
        endcase
    end

    assign load_use = in_valid && ex_load_valid &&
                      ((uses_rj && rj == ex_load_rd) || (uses_rk && rk == ex_load_rd));
    assign take     = !out_valid || next_rdy_in;
    assign rdy_in   = take && !load_use;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (flush)
            out_valid <= 1'b0;
        else if (take)
            out_valid <= in_valid && !load_use;         // Bubble while the load moves on
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            out_pc        <= in_pc;
            out_inst      <= in_inst;
            out_alu_op    <= alu_op;
            out_mem_op    <= mem_op;
            out_is_branch <= opc inside {op_beq, op_bne};
            out_branch_ne <= opc == op_bne;
            out_rd        <= f_rd;
            out_rj        <= rj;
            out_rk        <= rk;
            out_we        <= writes && f_rd != 5'd0;
            out_imm       <= imm;
            out_use_imm   <= opc inside {op_addi, op_lui, op_lw, op_sw};
            out_a         <= rj_data;
            out_b         <= rk_data;
        end
    end

endmodule

`default_nettype wire

// File: design/execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module execute (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic                  rdy_in,
    input  logic                  in_valid,
    input  logic [`CPU_XLEN-1:0]  in_pc,
    input  logic [`CPU_XLEN-1:0]  in_inst,
    input  cpu_pkg::alu_op_e      in_alu_op,
    input  cpu_pkg::mem_op_e      in_mem_op,
    input  logic                  in_is_branch,
    input  logic                  in_branch_ne,
    input  logic [4:0]            in_rd,
    input  logic [4:0]            in_rj,
    input  logic [4:0]            in_rk,
    input  logic                  in_we,
    input  logic [`CPU_XLEN-1:0]  in_imm,
    input  logic                  in_use_imm,
    input  logic [`CPU_XLEN-1:0]  in_a,
    input  logic [`CPU_XLEN-1:0]  in_b,
    input  logic                  fwd_valid,
    input  logic [4:0]            fwd_rd,
    input  logic [`CPU_XLEN-1:0]  fwd_data,
    output logic                  ex_load_valid,
    output logic [4:0]            ex_load_rd,
    output logic                  redirect,
    output logic [`CPU_XLEN-1:0]  target,
    input  logic                  next_rdy_in,
    output logic                  out_valid,
    output logic [`CPU_XLEN-1:0]  out_pc,
    output logic [`CPU_XLEN-1:0]  out_inst,
    output cpu_pkg::mem_op_e      out_mem_op,
    output logic [4:0]            out_rd,
    output logic                  out_we,
    output logic [`CPU_XLEN-1:0]  out_result,
    output logic [`CPU_XLEN-1:0]  out_store_data
);

    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] op_a;
    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] src2;
    logic [`CPU_XLEN-1:0] result;
    logic taken;

    assign op_a = (fwd_valid && in_rj != 5'd0 && fwd_rd == in_rj) ? fwd_data : in_a;
    assign op_b = (fwd_valid && in_rk != 5'd0 && fwd_rd == in_rk) ? fwd_data : in_b;
    assign src2 = in_use_imm ? in_imm : op_b;

    always_comb begin
        case (in_alu_op)
            alu_sub: result = op_a - src2;
            alu_and: result = op_a & src2;
            alu_or:  result = op_a | src2;
            alu_xor: result = op_a ^ src2;
            alu_slt: result = {{(`CPU_XLEN-1){1'b0}}, $signed(op_a) < $signed(src2)};
            alu_lui: result = src2;                     // Immediate already in upper half
            default: result = op_a + src2;
        endcase
    end

    assign taken    = in_is_branch && ((op_a == op_b) != in_branch_ne);
    assign rdy_in   = !out_valid || next_rdy_in;
    assign redirect = in_valid && taken && rdy_in;      // Only as the branch moves on
    assign target   = in_pc + {in_imm[`CPU_XLEN-3:0], 2'b00};

    assign ex_load_valid = in_valid && in_mem_op == mem_load && in_we;
    assign ex_load_rd    = in_rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (rdy_in)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            out_pc         <= in_pc;
            out_inst       <= in_inst;
            out_mem_op     <= in_mem_op;
            out_rd         <= in_rd;
            out_we         <= in_we;
            out_result     <= result;
            out_store_data <= op_b;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module fetch (
    input  logic                  clk,
    input  logic                  arst_n,
    output cpu_pkg::icache_op_e   icache_op,
    output logic [`CPU_XLEN-1:0]  icache_pa,
    input  logic [`CPU_XLEN-1:0]  icache_data,
    input  logic                  icache_busy,
    input  logic                  icache_data_valid,
    input  logic                  flush,
    input  logic [`CPU_XLEN-1:0]  target,
    input  logic                  next_rdy_in,
    output logic                  out_valid,
    output logic [`CPU_XLEN-1:0]  out_pc,
    output logic [`CPU_XLEN-1:0]  out_inst
);

    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] req_pc;
    logic pending;
    logic discard;
    logic req;
    logic ret;
    logic keep;

    // Output register is free by the time the single return comes back
    assign req  = !pending && !icache_busy && !flush && (!out_valid || next_rdy_in);
    assign ret  = pending && icache_data_valid;
    assign keep = ret && !discard && !flush;

    assign icache_op = req ? ic_read : ic_idle;
    assign icache_pa = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= `CPU_RESET_PC;
            pending   <= 1'b0;
            discard   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (flush)
                pc <= target;
            else if (req)
                pc <= pc + 4;
            if (req)
                pending <= 1'b1;
            else if (ret)
                pending <= 1'b0;
            if (ret)
                discard <= 1'b0;
            else if (flush && pending)
                discard <= 1'b1;                    // Stale return still in flight
            if (flush)
                out_valid <= 1'b0;
            else if (keep)
                out_valid <= 1'b1;
            else if (next_rdy_in)
                out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req)
            req_pc <= pc;
        if (keep) begin
            out_pc   <= req_pc;
            out_inst <= icache_data;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_wb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module mem_wb (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic                  rdy_in,
    input  logic                  in_valid,
    input  logic [`CPU_XLEN-1:0]  in_pc,
    input  logic [`CPU_XLEN-1:0]  in_inst,
    input  cpu_pkg::mem_op_e      in_mem_op,
    input  logic [4:0]            in_rd,
    input  logic                  in_we,
    input  logic [`CPU_XLEN-1:0]  in_result,
    input  logic [`CPU_XLEN-1:0]  in_store_data,
    output cpu_pkg::mem_op_e      dcache_op,
    output logic [`CPU_XLEN-1:0]  dcache_pa,
    output logic [`CPU_XLEN-1:0]  wr_dcache_data,
    input  logic [`CPU_XLEN-1:0]  rd_dcache_data,
    input  logic                  dcache_busy,
    input  logic                  dcache_data_valid,
    output logic                  reg_we,
    output logic [4:0]            reg_rd,
    output logic [`CPU_XLEN-1:0]  reg_data,
    output logic                  fwd_valid,
    output logic [4:0]            fwd_rd,
    output logic [`CPU_XLEN-1:0]  fwd_data,
    output logic                  debug_wb_valid,
    output logic [`CPU_XLEN-1:0]  debug_wb_pc,
    output logic [`CPU_XLEN-1:0]  debug_wb_inst,
    output logic [3:0]            debug_wb_rf_wen,
    output logic [4:0]            debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0]  debug_wb_rf_wdata
);

    import cpu_pkg::*;

    typedef enum logic [1:0] {st_idle, st_req, st_wait} state_e;

    state_e state;
    state_e phase;
    logic next_rdy_in;
    logic issue;
    logic done;
    logic [`CPU_XLEN-1:0] wb_data;

    assign next_rdy_in = 1'b1;                          // Nothing downstream

    // The register only remembers an issued load, a held item needs its request
    always_comb begin
        if (state == st_wait)
            phase = st_wait;
        else if (in_valid && in_mem_op != mem_none)
            phase = st_req;
        else
            phase = st_idle;
    end

    assign issue = phase == st_req && !dcache_busy;
    assign done  = in_valid && (phase == st_idle || (issue && in_mem_op == mem_store) ||
                                (phase == st_wait && dcache_data_valid));
    assign rdy_in = !in_valid || (done && next_rdy_in);

    assign dcache_op      = issue ? in_mem_op : mem_none;
    assign dcache_pa      = in_result;
    assign wr_dcache_data = in_store_data;

    assign wb_data   = (in_mem_op == mem_load) ? rd_dcache_data : in_result;
    assign reg_we    = done && in_we;
    assign reg_rd    = in_rd;
    assign reg_data  = wb_data;
    assign fwd_valid = reg_we;                          // Pending load forwards nothing
    assign fwd_rd    = in_rd;
    assign fwd_data  = wb_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= st_idle;
            debug_wb_valid  <= 1'b0;
            debug_wb_rf_wen <= 4'h0;
        end else begin
            if (issue && in_mem_op == mem_load)
                state <= st_wait;
            else if (dcache_data_valid)
                state <= st_idle;
            debug_wb_valid  <= done;
            debug_wb_rf_wen <= {4{reg_we}};
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            debug_wb_pc       <= in_pc;
            debug_wb_inst     <= in_inst;
            debug_wb_rf_wnum  <= in_rd;
            debug_wb_rf_wdata <= wb_data;
        end
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [4:0]           rj,
    input  logic [4:0]           rk,
    output logic [`CPU_XLEN-1:0] rj_data,
    output logic [`CPU_XLEN-1:0] rk_data,
    input  logic                 we,
    input  logic [4:0]           rd,
    input  logic [`CPU_XLEN-1:0] rd_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREG];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_NREG; i++)
                regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    // Same-cycle write is visible to decode
    assign rj_data = (rj == 5'd0) ? '0 : (we && rd == rj) ? rd_data : regs[rj];
    assign rk_data = (rk == 5'd0) ? '0 : (we && rd == rk) ? rd_data : regs[rk];

endmodule

`default_nettype wire

// File: testbench/tb_cpu_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu_mem (
    input  logic                  clk,
    input  logic                  arst_n,
    input  cpu_pkg::icache_op_e   icache_op,
    input  logic [`CPU_XLEN-1:0]  icache_pa,
    output logic [`CPU_XLEN-1:0]  icache_data,
    output logic                  icache_busy,
    output logic                  icache_data_valid,
    input  cpu_pkg::mem_op_e      dcache_op,
    input  logic [`CPU_XLEN-1:0]  dcache_pa,
    input  logic [`CPU_XLEN-1:0]  wr_dcache_data,
    output logic [`CPU_XLEN-1:0]  rd_dcache_data,
    output logic                  dcache_busy,
    output logic                  dcache_data_valid
);

    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] imem [256];                   // Loaded by the testbench top
    logic [`CPU_XLEN-1:0] dmem [256];

    integer seed;
    logic in_reset;
    logic ic_take;
    logic dc_load;
    logic dc_store;
    logic [7:0] ic_index;
    logic [7:0] dc_index;
    logic [`CPU_XLEN-1:0] dc_wdata;
    int ic_left;
    int dc_left;

    initial begin
        seed              = 32'h7b3e_46cb;
        icache_data       = '0;
        icache_busy       = 1'b0;
        icache_data_valid = 1'b0;
        rd_dcache_data    = '0;
        dcache_busy       = 1'b0;
        dcache_data_valid = 1'b0;
        ic_left           = 0;
        dc_left           = 0;
    end

    always @(posedge clk) begin
        in_reset = !arst_n;
        ic_take  = icache_op == ic_read && !icache_busy;
        dc_load  = dcache_op == mem_load && !dcache_busy;
        dc_store = dcache_op == mem_store && !dcache_busy;
        if (ic_take)
            ic_index = icache_pa[9:2];
        if (dc_load || dc_store)
            dc_index = dcache_pa[9:2];
        dc_wdata = wr_dcache_data;
        #2;                                             // Answer moves just after the edge
        icache_data_valid = 1'b0;
        dcache_data_valid = 1'b0;
        if (in_reset) begin
            icache_busy = 1'b0;
            dcache_busy = 1'b0;
            ic_left     = 0;
            dc_left     = 0;
        end else begin
            if (dc_store)
                dmem[dc_index] = dc_wdata;
            if (ic_take)
                ic_left = 1 + $unsigned($random(seed)) % 4;
            if (dc_load)
                dc_left = 1 + $unsigned($random(seed)) % 4;
            if (ic_left != 0) begin
                ic_left = ic_left - 1;
                if (ic_left == 0) begin
                    icache_data       = imem[ic_index];
                    icache_data_valid = 1'b1;
                end
            end
            if (dc_left != 0) begin
                dc_left = dc_left - 1;
                if (dc_left == 0) begin
                    rd_dcache_data    = dmem[dc_index];
                    dcache_data_valid = 1'b1;
                end
            end
            icache_busy = ($random(seed) & 3) == 0;     // Busy about a quarter of the time
            dcache_busy = ($random(seed) & 3) == 0;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu_top;

    import cpu_pkg::*;

    localparam int prog_len     = 201;                 // Random part plus the final self-loop
    localparam int retire_limit = 400;

    logic clk;
    logic arst_n;
    icache_op_e icache_op;
    logic [`CPU_XLEN-1:0] icache_pa;
    logic [`CPU_XLEN-1:0] icache_data;
    logic icache_busy;
    logic icache_data_valid;
    mem_op_e dcache_op;
    logic [`CPU_XLEN-1:0] dcache_pa;
    logic [`CPU_XLEN-1:0] wr_dcache_data;
    logic [`CPU_XLEN-1:0] rd_dcache_data;
    logic dcache_busy;
    logic dcache_data_valid;
    logic debug_wb_valid;
    logic [`CPU_XLEN-1:0] debug_wb_pc;
    logic [`CPU_XLEN-1:0] debug_wb_inst;
    logic [3:0] debug_wb_rf_wen;
    logic [4:0] debug_wb_rf_wnum;
    logic [`CPU_XLEN-1:0] debug_wb_rf_wdata;

    logic [`CPU_XLEN-1:0] prog [prog_len];
    logic [`CPU_XLEN-1:0] model_rf [`CPU_NREG];
    logic [`CPU_XLEN-1:0] model_mem [256];
    logic [`CPU_XLEN-1:0] model_pc;
    logic [`CPU_XLEN-1:0] exp_pc;
    logic [`CPU_XLEN-1:0] exp_inst;
    logic [`CPU_XLEN-1:0] exp_data;
    logic [3:0] exp_wen;
    logic [4:0] exp_wnum;
    logic store_seen;
    logic at_end;
    integer seed;

    cpu_top uut (
        .clk, .arst_n,
        .icache_op, .icache_pa, .icache_data, .icache_busy, .icache_data_valid,
        .dcache_op, .dcache_pa, .wr_dcache_data, .rd_dcache_data,
        .dcache_busy, .dcache_data_valid,
        .debug_wb_valid, .debug_wb_pc, .debug_wb_inst,
        .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    tb_cpu_mem u_mem (
        .clk, .arst_n,
        .icache_op, .icache_pa, .icache_data, .icache_busy, .icache_data_valid,
        .dcache_op, .dcache_pa, .wr_dcache_data, .rd_dcache_data,
        .dcache_busy, .dcache_data_valid
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [`CPU_XLEN-1:0] encode(input opcode_e opc, input logic [4:0] rd,
            input logic [4:0] rj, input logic [4:0] rk, input logic [15:0] imm);
        logic [`CPU_XLEN-1:0] word;
        word = '0;
        word[`CPU_IMM_W-1:0]    = imm;
        word[`CPU_OPC_LSB +: 4] = opc;
        word[`CPU_RD_LSB +: 5]  = rd;
        word[`CPU_RJ_LSB +: 5]  = rj;
        word[`CPU_RK_LSB +: 5]  = word[`CPU_RK_LSB +: 5] | rk;  // rk overlaps the immediate
        return word;
    endfunction

    function automatic logic [`CPU_XLEN-1:0] imm_of(input logic [`CPU_XLEN-1:0] inst);
        return {{(`CPU_XLEN-`CPU_IMM_W){inst[`CPU_IMM_W-1]}}, inst[`CPU_IMM_W-1:0]};
    endfunction

    function automatic logic [`CPU_XLEN-1:0] data_fill(input int index);
        return {16'hda7a, 6'd0, index[7:0], 2'b00};    // Shows the byte address
    endfunction

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic value_error(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        report_fail($sformatf("CHECK FAILED at %0t ns: %s expected %h, got %h",
                              $time, what, expected, actual));
    endtask

    task automatic build_program;
        int unsigned pick;
        int unsigned off;
        opcode_e opc;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        logic [15:0] imm;
        for (int k = 0; k < prog_len - 1; k++) begin
            pick = $unsigned($random(seed)) % 12;
            opc  = opcode_e'(pick[3:0]);
            rd   = 5'($random(seed) & 7);               // Few registers, many hazards
            rj   = 5'($random(seed) & 7);
            rk   = 5'($random(seed) & 7);
            imm  = 16'($random(seed));
            case (opc)
                op_addi:        prog[k] = encode(opc, rd, rj, 5'd0, imm);
                op_lui:         prog[k] = encode(opc, rd, 5'd0, 5'd0, imm);
                op_lw, op_sw:   prog[k] = encode(opc, rd, 5'd0, 5'd0, {6'd0, imm[7:0], 2'b00});
                op_beq, op_bne: begin
                    off = 1 + $unsigned($random(seed)) % 4;
                    if (k + off > prog_len - 1)
                        off = prog_len - 1 - k;
                    prog[k] = encode(opc, rd, rj, 5'd0, 16'(off));
                end
                default:        prog[k] = encode(opc, rd, rj, rk, 16'h0);
            endcase
        end
        prog[prog_len-1] = encode(op_beq, 5'd0, 5'd0, 5'd0, 16'h0);
    endtask

    task automatic load_memories;
        for (int i = 0; i < 256; i++) begin
            if (i < prog_len)
                u_mem.imem[i] = prog[i];
            else
                u_mem.imem[i] = encode(op_add, 5'd0, 5'd0, 5'd0, 16'(i * 4));
            u_mem.dmem[i] = data_fill(i);
            model_mem[i]  = data_fill(i);
        end
        for (int r = 0; r < `CPU_NREG; r++)
            model_rf[r] = '0;
    endtask

    // Executes the instruction at model_pc and records what its retirement must show
    task automatic model_step;
        logic [`CPU_XLEN-1:0] inst;
        logic [`CPU_XLEN-1:0] a;
        logic [`CPU_XLEN-1:0] b;
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] next_pc;
        opcode_e opc;
        logic [4:0] rd;
        inst     = prog[model_pc >> 2];
        opc      = opcode_e'(inst[`CPU_OPC_LSB +: 4]);
        rd       = inst[`CPU_RD_LSB +: 5];
        a        = model_rf[inst[`CPU_RJ_LSB +: 5]];
        b        = model_rf[inst[`CPU_RK_LSB +: 5]];
        addr     = a + imm_of(inst);
        next_pc  = model_pc + 4;
        exp_pc   = model_pc;
        exp_inst = inst;
        exp_wnum = rd;
        exp_wen  = 4'hf;
        exp_data = '0;
        case (opc)
            op_add:  exp_data = a + b;
            op_sub:  exp_data = a - b;
            op_and:  exp_data = a & b;
            op_or:   exp_data = a | b;
            op_xor:  exp_data = a ^ b;
            op_slt:  exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_addi: exp_data = addr;
            op_lui:  exp_data = {inst[15:0], 16'h0};
            op_lw:   exp_data = model_mem[addr[9:2]];
            op_sw: begin
                exp_wen = 4'h0;
                if (!store_seen)
                    report_fail($sformatf("Store at pc %h retired without a data request",
                                          model_pc));
                store_seen            = 1'b0;
                model_mem[addr[9:2]] = model_rf[rd];
            end
            op_beq, op_bne: begin
                exp_wen = 4'h0;
                if ((a == model_rf[rd]) == (opc == op_beq))
                    next_pc = model_pc + (imm_of(inst) << 2);
            end
            default: report_fail($sformatf("Program holds an unknown opcode at pc %h", model_pc));
        endcase
        if (rd == 5'd0)
            exp_wen = 4'h0;
        if (exp_wen != 4'h0)
            model_rf[rd] = exp_data;
        at_end   = opc == op_beq && next_pc == model_pc;
        model_pc = next_pc;
    endtask

    task automatic check_wb(input logic [`CPU_XLEN-1:0] pc, input logic [`CPU_XLEN-1:0] inst,
            input logic [3:0] wen, input logic [4:0] wnum, input logic [`CPU_XLEN-1:0] data);
        if (pc !== exp_pc)
            value_error("retired pc", exp_pc, pc);
        if (inst !== exp_inst)
            value_error($sformatf("instruction at pc %h", exp_pc), exp_inst, inst);
        if (wen !== exp_wen)
            value_error($sformatf("write enable at pc %h", exp_pc), exp_wen, wen);
        if (wnum !== exp_wnum)
            value_error($sformatf("register number at pc %h", exp_pc), exp_wnum, wnum);
        if (exp_wen != 4'h0 && data !== exp_data)
            value_error($sformatf("write data at pc %h", exp_pc), exp_data, data);
    endtask

    task automatic check_store(input mem_op_e op, input logic [`CPU_XLEN-1:0] addr,
            input logic [`CPU_XLEN-1:0] data);
        logic [`CPU_XLEN-1:0] inst;
        logic is_sw;
        inst  = prog[model_pc >> 2];
        is_sw = opcode_e'(inst[`CPU_OPC_LSB +: 4]) == op_sw;
        if (op == mem_store && (!is_sw || store_seen))
            report_fail($sformatf("Unexpected data-cache store at %0t ns, next pc %h",
                                  $time, model_pc));
        if (is_sw && !store_seen) begin
            if (op !== mem_store)
                value_error($sformatf("data-cache op at pc %h", model_pc), mem_store, op);
            if (addr !== model_rf[inst[`CPU_RJ_LSB +: 5]] + imm_of(inst))
                value_error($sformatf("store address at pc %h", model_pc),
                            model_rf[inst[`CPU_RJ_LSB +: 5]] + imm_of(inst), addr);
            if (data !== model_rf[inst[`CPU_RD_LSB +: 5]])
                value_error($sformatf("store data at pc %h", model_pc),
                            model_rf[inst[`CPU_RD_LSB +: 5]], data);
            store_seen = 1'b1;
        end
    endtask

    // One mid-cycle look at both ports and the trace
    task automatic sample_cycle(output logic retired);
        retired = 1'b0;
        if (icache_op == ic_read && icache_busy)
            report_fail($sformatf("Instruction request issued while busy at %0t ns", $time));
        if (dcache_op != mem_none && dcache_busy)
            report_fail($sformatf("Data request issued while busy at %0t ns", $time));
        if (debug_wb_valid) begin
            model_step();
            check_wb(debug_wb_pc, debug_wb_inst, debug_wb_rf_wen, debug_wb_rf_wnum,
                     debug_wb_rf_wdata);
            retired = 1'b1;
        end
        if (dcache_op != mem_none)
            check_store(dcache_op, dcache_pa, wr_dcache_data);
    endtask

    initial begin
        int waited;
        logic retired;
        seed       = 32'h7b3e_46cb;
        arst_n     = 1'b0;
        at_end     = 1'b0;
        store_seen = 1'b0;
        model_pc   = `CPU_RESET_PC;
        build_program();
        load_memories();
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        while (!at_end) begin
            waited  = 0;
            retired = 1'b0;
            while (!retired) begin
                @(negedge clk);
                sample_cycle(retired);
                waited++;
                if (!retired && waited >= retire_limit)
                    report_fail($sformatf("Timeout, nothing retired for %0d cycles, next pc %h",
                                          retire_limit, model_pc));
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
